// File: verilog/t2_consts.svh
`ifndef T2_CONSTS_SVH
`define T2_CONSTS_SVH

`default_nettype none

// Field and sample widths
`define T2_ZB_W        6
`define T2_PASS_W      9
`define T2_FIELD_W     32
`define T2_BITCNT_W    6
`define T2_PKT_IDX_W   16

// Precinct geometry, 8x8 code blocks reduced over three levels
`define T2_GRID        8
`define T2_LEVELS      3

// SOP marker followed by its segment length
`define T2_SOP_WORD    32'hFF91_0004

`default_nettype wire

`endif

// File: verilog/t2_pkg.sv
`include "t2_consts.svh"
`default_nettype none

package t2_pkg;

    typedef logic [`T2_ZB_W-1:0]              zb_t;
    typedef logic [`T2_PASS_W-1:0]            pass_t;
    typedef logic [`T2_FIELD_W-1:0]           field_t;
    typedef logic [`T2_BITCNT_W-1:0]          bit_cnt_t;
    typedef logic [$clog2(`T2_GRID)-1:0]      cb_coord_t;
    typedef logic [`T2_PKT_IDX_W-1:0]         pkt_index_t;

    // Header generator FSM
    typedef enum logic [2:0] {
        HDR_IDLE,
        HDR_SOP,
        HDR_INDEX,
        HDR_TAG,
        HDR_PASS,
        HDR_LAST_WAIT
    } hdr_state_t;

endpackage

`default_nettype wire

// File: verilog/tag_tree_if.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

interface tag_tree_if;

    // Level k holds (8>>k)^2 nodes in raster order, rest unused
    t2_pkg::zb_t node [`T2_LEVELS+1][`T2_GRID*`T2_GRID];

    // One-cycle strobe per level, set when that level has new values
    logic        load [`T2_LEVELS+1];

    // High while a packet header is being emitted
    logic        busy;

    modport fill_mp (
        output node,
        output load,
        input  busy
    );

    // A level reads node/load k and drives node/load k+1
    modport level_mp (
        output node,
        output load
    );

    modport hdr_mp (
        input  node,
        input  load,
        output busy
    );

endinterface

`default_nettype wire

// File: verilog/zero_plane_fill.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

module zero_plane_fill (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            zb_valid_i,
    input  t2_pkg::zb_t     zb_data_i,
    output logic            zb_ready_o,

    tag_tree_if.fill_mp     tree
);

    localparam int N_LEAF = `T2_GRID * `T2_GRID;
    localparam int CNT_W  = $clog2(N_LEAF);

    logic [CNT_W-1:0]   wr_cnt;
    logic               full;
    logic               load_q;
    logic               take;
    logic               copy;

    t2_pkg::zb_t        fill_buf [N_LEAF];
    t2_pkg::zb_t        leaf_q   [N_LEAF];

    assign zb_ready_o = !full;
    assign take       = zb_valid_i && !full;

    // Hand over only when the previous header is done with the leaves
    assign copy       = full && !tree.busy;

    //------------------------------------------------------------
    // Write counter and full flag
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            full   <= 1'b0;
            load_q <= 1'b0;
        end else begin
            load_q <= 1'b0;
            if (take) begin
                // Counter wraps to zero on the 64th value
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == CNT_W'(N_LEAF - 1)) begin
                    full <= 1'b1;
                end
            end else if (copy) begin
                full   <= 1'b0;
                load_q <= 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // Fill buffer and leaf snapshot
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            fill_buf[wr_cnt] <= zb_data_i;
        end
        if (copy) begin
            leaf_q <= fill_buf;
        end
    end

    assign tree.node[0] = leaf_q;
    assign tree.load[0] = load_q;

endmodule

`default_nettype wire

// File: verilog/tag_tree_level.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

module tag_tree_level #(
    parameter int SIDE_IN = 8,
    parameter int LEVEL   = 0
) (
    input  logic            clk,
    input  logic            rst_n,

    tag_tree_if.level_mp    tree
);

    localparam int SIDE_OUT = SIDE_IN / 2;
    localparam int N_OUT    = SIDE_OUT * SIDE_OUT;
    localparam int N_ALL    = `T2_GRID * `T2_GRID;

    logic load_q;

    // Parent node is the minimum of its 2x2 children
    for (genvar oy = 0; oy < SIDE_OUT; oy++) begin : g_row
        for (genvar ox = 0; ox < SIDE_OUT; ox++) begin : g_col
            localparam int C0 = (2 * oy) * SIDE_IN + 2 * ox;
            localparam int C1 = C0 + SIDE_IN;

            t2_pkg::zb_t top_min;
            t2_pkg::zb_t bot_min;
            t2_pkg::zb_t min_q;

            assign top_min = (tree.node[LEVEL][C0] < tree.node[LEVEL][C0+1]) ?
                             tree.node[LEVEL][C0] : tree.node[LEVEL][C0+1];
            assign bot_min = (tree.node[LEVEL][C1] < tree.node[LEVEL][C1+1]) ?
                             tree.node[LEVEL][C1] : tree.node[LEVEL][C1+1];

            always_ff @(posedge clk) begin
                if (tree.load[LEVEL]) begin
                    min_q <= (top_min < bot_min) ? top_min : bot_min;
                end
            end

            assign tree.node[LEVEL+1][oy*SIDE_OUT+ox] = min_q;
        end
    end

    // Entries beyond this level's grid are tied off
    for (genvar i = N_OUT; i < N_ALL; i++) begin : g_unused
        assign tree.node[LEVEL+1][i] = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= tree.load[LEVEL];
        end
    end

    assign tree.load[LEVEL+1] = load_q;

endmodule

`default_nettype wire

// File: verilog/packet_header_gen.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

module packet_header_gen (
    input  logic                clk,
    input  logic                rst_n,

    tag_tree_if.hdr_mp          tree,

    input  logic                pass_valid_i,
    input  t2_pkg::pass_t       pass_data_i,
    output logic                pass_ready_o,

    output logic                hdr_valid_o,
    output logic                hdr_last_o,
    output t2_pkg::field_t      hdr_data_o,
    output t2_pkg::bit_cnt_t    hdr_bit_cnt_o,
    output logic                hdr_insert_zero_o,
    input  logic                hdr_ready_i
);

    localparam t2_pkg::cb_coord_t CB_LAST = t2_pkg::cb_coord_t'(`T2_GRID - 1);

    t2_pkg::hdr_state_t     state;
    t2_pkg::cb_coord_t      cb_y;
    t2_pkg::cb_coord_t      cb_x;
    logic [1:0]             tag_lvl;
    t2_pkg::pkt_index_t     pkt_idx;
    logic                   busy_q;
    logic                   fire;

    t2_pkg::cb_coord_t      tag_y;
    t2_pkg::cb_coord_t      tag_x;
    logic [1:0]             tag_lvl_n;
    t2_pkg::zb_t            tag_val;

    t2_pkg::pass_t          d3;
    t2_pkg::pass_t          d6;
    t2_pkg::pass_t          d37;
    t2_pkg::field_t         code_data;
    t2_pkg::bit_cnt_t       code_bits;

    // Highest tree level first visible at block (y, x)
    function automatic logic [1:0] first_level(input t2_pkg::cb_coord_t y,
                                               input t2_pkg::cb_coord_t x);
        if (y == '0 && x == '0) begin
            return 2'd3;
        end else if (y[1:0] == 2'b00 && x[1:0] == 2'b00) begin
            return 2'd2;
        end else if (!y[0] && !x[0]) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    assign fire         = hdr_valid_o && hdr_ready_i;
    assign pass_ready_o = (state == t2_pkg::HDR_PASS) && !hdr_valid_o;
    assign tree.busy    = busy_q;

    //------------------------------------------------------------
    // Next tag field: block and level to present after a transfer
    //------------------------------------------------------------
    always_comb begin
        tag_y     = cb_y;
        tag_x     = cb_x;
        tag_lvl_n = tag_lvl - 2'd1;
        if (state == t2_pkg::HDR_INDEX) begin
            tag_y     = '0;
            tag_x     = '0;
            tag_lvl_n = 2'd3;
        end else if (state == t2_pkg::HDR_PASS) begin
            // Raster step to the next code block
            {tag_y, tag_x} = {cb_y, cb_x} + 1'b1;
            tag_lvl_n      = first_level(tag_y, tag_x);
        end

        case (tag_lvl_n)
            2'd3:    tag_val = tree.node[3][0];
            2'd2:    tag_val = tree.node[2][{tag_y[2], tag_x[2]}];
            2'd1:    tag_val = tree.node[1][{tag_y[2:1], tag_x[2:1]}];
            default: tag_val = tree.node[0][{tag_y, tag_x}];
        endcase
    end

    //------------------------------------------------------------
    // Pass-count codeword
    //------------------------------------------------------------
    assign d3  = pass_data_i - 9'd3;
    assign d6  = pass_data_i - 9'd6;
    assign d37 = pass_data_i - 9'd37;

    always_comb begin
        if (pass_data_i == 9'd1) begin
            code_data = '0;
            code_bits = 6'd1;
        end else if (pass_data_i == 9'd2) begin
            code_data = t2_pkg::field_t'(2'b10);
            code_bits = 6'd2;
        end else if (pass_data_i <= 9'd5) begin
            code_data = t2_pkg::field_t'({2'b11, d3[1:0]});
            code_bits = 6'd4;
        end else if (pass_data_i <= 9'd36) begin
            code_data = t2_pkg::field_t'({4'b1111, d6[4:0]});
            code_bits = 6'd9;
        end else begin
            code_data = t2_pkg::field_t'({9'h1ff, d37[6:0]});
            code_bits = 6'd16;
        end
    end

    //------------------------------------------------------------
    // Header FSM
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= t2_pkg::HDR_IDLE;
            cb_y              <= '0;
            cb_x              <= '0;
            tag_lvl           <= '0;
            pkt_idx           <= '0;
            busy_q            <= 1'b0;
            hdr_valid_o       <= 1'b0;
            hdr_last_o        <= 1'b0;
            hdr_data_o        <= '0;
            hdr_bit_cnt_o     <= '0;
            hdr_insert_zero_o <= 1'b0;
        end else begin
            case (state)
                t2_pkg::HDR_IDLE: begin
                    if (tree.load[0]) begin
                        busy_q <= 1'b1;
                    end
                    if (tree.load[3]) begin
                        state         <= t2_pkg::HDR_SOP;
                        hdr_valid_o   <= 1'b1;
                        hdr_data_o    <= `T2_SOP_WORD;
                        hdr_bit_cnt_o <= 6'd32;
                    end
                end
                t2_pkg::HDR_SOP: begin
                    if (fire) begin
                        state         <= t2_pkg::HDR_INDEX;
                        hdr_data_o    <= t2_pkg::field_t'(pkt_idx);
                        hdr_bit_cnt_o <= 6'd16;
                    end
                end
                t2_pkg::HDR_INDEX, t2_pkg::HDR_TAG: begin
                    if (fire) begin
                        if (state == t2_pkg::HDR_TAG && tag_lvl == 2'd0) begin
                            // Leaf sent, wait for the pass count
                            state             <= t2_pkg::HDR_PASS;
                            hdr_valid_o       <= 1'b0;
                            hdr_insert_zero_o <= 1'b0;
                        end else begin
                            state             <= t2_pkg::HDR_TAG;
                            tag_lvl           <= tag_lvl_n;
                            hdr_data_o        <= t2_pkg::field_t'(tag_val);
                            hdr_bit_cnt_o     <= t2_pkg::bit_cnt_t'(tag_val) + 1'b1;
                            hdr_insert_zero_o <= 1'b1;
                        end
                    end
                end
                t2_pkg::HDR_PASS: begin
                    if (!hdr_valid_o && pass_valid_i) begin
                        hdr_valid_o   <= 1'b1;
                        hdr_data_o    <= code_data;
                        hdr_bit_cnt_o <= code_bits;
                        if (cb_y == CB_LAST && cb_x == CB_LAST) begin
                            state      <= t2_pkg::HDR_LAST_WAIT;
                            hdr_last_o <= 1'b1;
                        end
                    end else if (fire) begin
                        // Codeword taken, open the next block
                        state             <= t2_pkg::HDR_TAG;
                        cb_y              <= tag_y;
                        cb_x              <= tag_x;
                        tag_lvl           <= tag_lvl_n;
                        hdr_data_o        <= t2_pkg::field_t'(tag_val);
                        hdr_bit_cnt_o     <= t2_pkg::bit_cnt_t'(tag_val) + 1'b1;
                        hdr_insert_zero_o <= 1'b1;
                    end
                end
                t2_pkg::HDR_LAST_WAIT: begin
                    if (fire) begin
                        state       <= t2_pkg::HDR_IDLE;
                        hdr_valid_o <= 1'b0;
                        hdr_last_o  <= 1'b0;
                        busy_q      <= 1'b0;
                        cb_y        <= '0;
                        cb_x        <= '0;
                        pkt_idx     <= pkt_idx + 1'b1;
                    end
                end
                default: begin
                    state <= t2_pkg::HDR_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/t2_header_top.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

module t2_header_top (
    input  logic                clk,
    input  logic                rst_n,

    // Zero-bitplane stream, 64 values per tile in raster order
    input  logic                zb_valid_i,
    input  t2_pkg::zb_t         zb_data_i,
    output logic                zb_ready_o,

    // Pass counts, one per code block
    input  logic                pass_valid_i,
    input  t2_pkg::pass_t       pass_data_i,
    output logic                pass_ready_o,

    // Header field stream
    output logic                hdr_valid_o,
    output logic                hdr_last_o,
    output t2_pkg::field_t      hdr_data_o,
    output t2_pkg::bit_cnt_t    hdr_bit_cnt_o,
    output logic                hdr_insert_zero_o,
    input  logic                hdr_ready_i
);

    tag_tree_if tree ();

    zero_plane_fill u_fill (
        .clk        (clk),
        .rst_n      (rst_n),
        .zb_valid_i (zb_valid_i),
        .zb_data_i  (zb_data_i),
        .zb_ready_o (zb_ready_o),
        .tree       (tree.fill_mp)
    );

    // 8x8 -> 4x4 -> 2x2 -> 1
    for (genvar k = 0; k < `T2_LEVELS; k++) begin : g_level
        tag_tree_level #(
            .SIDE_IN (`T2_GRID >> k),
            .LEVEL   (k)
        ) u_level (
            .clk   (clk),
            .rst_n (rst_n),
            .tree  (tree.level_mp)
        );
    end

    packet_header_gen u_hdr (
        .clk               (clk),
        .rst_n             (rst_n),
        .tree              (tree.hdr_mp),
        .pass_valid_i      (pass_valid_i),
        .pass_data_i       (pass_data_i),
        .pass_ready_o      (pass_ready_o),
        .hdr_valid_o       (hdr_valid_o),
        .hdr_last_o        (hdr_last_o),
        .hdr_data_o        (hdr_data_o),
        .hdr_bit_cnt_o     (hdr_bit_cnt_o),
        .hdr_insert_zero_o (hdr_insert_zero_o),
        .hdr_ready_i       (hdr_ready_i)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_t2_header.sv
`timescale 1ns/1ps
`include "t2_consts.svh"
`default_nettype none

module tb_t2_header;

    localparam int N_TILES    = 3;
    localparam int N_CB       = `T2_GRID * `T2_GRID;
    localparam int MAX_CYCLES = 20000;

    logic                   clk;
    logic                   rst_n;
    logic                   zb_valid_i;
    t2_pkg::zb_t            zb_data_i;
    logic                   zb_ready_o;
    logic                   pass_valid_i;
    t2_pkg::pass_t          pass_data_i;
    logic                   pass_ready_o;
    logic                   hdr_valid_o;
    logic                   hdr_last_o;
    t2_pkg::field_t         hdr_data_o;
    t2_pkg::bit_cnt_t       hdr_bit_cnt_o;
    logic                   hdr_insert_zero_o;
    logic                   hdr_ready_i;

    logic [31:0]            lfsr_state;
    t2_pkg::zb_t            tile_vals [N_TILES][N_CB];
    t2_pkg::pass_t          pass_vals [N_TILES][N_CB];

    // Expected header stream, one entry per field
    t2_pkg::field_t         exp_data [$];
    t2_pkg::bit_cnt_t       exp_bits [$];
    logic                   exp_zero [$];
    logic                   exp_last [$];

    int                     zb_sent;
    int                     pass_sent;
    int                     packets_done;
    int                     cycles;
    int                     t;
    int                     i;
    logic                   zb_fire;
    logic                   pass_fire;

    // Field seen waiting for hdr_ready_i in the previous cycle
    logic                   hold_pending;
    t2_pkg::field_t         held_data;
    t2_pkg::bit_cnt_t       held_bits;
    logic                   held_zero;
    logic                   held_last;

    tb_clock u_clock (
        .clk_o (clk)
    );

    t2_header_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .zb_valid_i        (zb_valid_i),
        .zb_data_i         (zb_data_i),
        .zb_ready_o        (zb_ready_o),
        .pass_valid_i      (pass_valid_i),
        .pass_data_i       (pass_data_i),
        .pass_ready_o      (pass_ready_o),
        .hdr_valid_o       (hdr_valid_o),
        .hdr_last_o        (hdr_last_o),
        .hdr_data_o        (hdr_data_o),
        .hdr_bit_cnt_o     (hdr_bit_cnt_o),
        .hdr_insert_zero_o (hdr_insert_zero_o),
        .hdr_ready_i       (hdr_ready_i)
    );

    //------------------------------------------------------------
    // Random numbers and reference model
    //------------------------------------------------------------

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          k;
        val = '0;
        for (k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // Pick one of the five codeword ranges, then a count inside it
    function automatic t2_pkg::pass_t random_pass_count();
        logic [31:0] range;
        range = rand_bits(3) % 5;
        case (range)
            0:       return t2_pkg::pass_t'(1);
            1:       return t2_pkg::pass_t'(2);
            2:       return t2_pkg::pass_t'(3 + rand_bits(2) % 3);
            3:       return t2_pkg::pass_t'(6 + rand_bits(5) % 31);
            default: return t2_pkg::pass_t'(37 + rand_bits(7));
        endcase
    endfunction

    function automatic void expected_codeword(input t2_pkg::pass_t count,
                                              output t2_pkg::field_t data,
                                              output t2_pkg::bit_cnt_t bits);
        int c;
        c = int'(count);
        if (c == 1) begin
            data = '0;
            bits = 6'd1;
        end else if (c == 2) begin
            data = 32'h2;
            bits = 6'd2;
        end else if (c <= 5) begin
            data = t2_pkg::field_t'(12 + c - 3);
            bits = 6'd4;
        end else if (c <= 36) begin
            data = t2_pkg::field_t'((15 << 5) + c - 6);
            bits = 6'd9;
        end else begin
            data = t2_pkg::field_t'((511 << 7) + c - 37);
            bits = 6'd16;
        end
    endfunction

    // Minimum over the size x size block region at (y0, x0)
    function automatic t2_pkg::zb_t region_min(input int tile, input int y0,
                                               input int x0, input int size);
        t2_pkg::zb_t m;
        int          y;
        int          x;
        m = tile_vals[tile][y0 * `T2_GRID + x0];
        for (y = y0; y < y0 + size; y++) begin
            for (x = x0; x < x0 + size; x++) begin
                if (tile_vals[tile][y * `T2_GRID + x] < m) begin
                    m = tile_vals[tile][y * `T2_GRID + x];
                end
            end
        end
        return m;
    endfunction

    function automatic void push_field(input t2_pkg::field_t data,
                                       input t2_pkg::bit_cnt_t bits,
                                       input logic zero, input logic last);
        exp_data.push_back(data);
        exp_bits.push_back(bits);
        exp_zero.push_back(zero);
        exp_last.push_back(last);
    endfunction

    function automatic void push_tag(input int tile, input int y, input int x, input int size);
        t2_pkg::zb_t m;
        m = region_min(tile, y, x, size);
        push_field(t2_pkg::field_t'(m), t2_pkg::bit_cnt_t'(int'(m) + 1), 1'b1, 1'b0);
    endfunction

    function automatic void build_packet(input int tile);
        t2_pkg::field_t   code;
        t2_pkg::bit_cnt_t code_bits;
        int               y;
        int               x;
        push_field(`T2_SOP_WORD, 6'd32, 1'b0, 1'b0);
        push_field(t2_pkg::field_t'(tile), 6'd16, 1'b0, 1'b0);
        for (y = 0; y < `T2_GRID; y++) begin
            for (x = 0; x < `T2_GRID; x++) begin
                if (y == 0 && x == 0) begin
                    push_tag(tile, y, x, 8);
                end
                if (y % 4 == 0 && x % 4 == 0) begin
                    push_tag(tile, y, x, 4);
                end
                if (y % 2 == 0 && x % 2 == 0) begin
                    push_tag(tile, y, x, 2);
                end
                push_tag(tile, y, x, 1);
                expected_codeword(pass_vals[tile][y * `T2_GRID + x], code, code_bits);
                push_field(code, code_bits, 1'b0, (y == 7 && x == 7));
            end
        end
    endfunction

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input t2_pkg::field_t got,
                               input t2_pkg::field_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit_cnt(input string name, input t2_pkg::bit_cnt_t got,
                                 input t2_pkg::bit_cnt_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Runs mid-cycle, where every DUT input and output is settled
    task automatic check_header_stream();
        t2_pkg::field_t   e_data;
        t2_pkg::bit_cnt_t e_bits;
        logic             e_zero;
        logic             e_last;
        if (hold_pending) begin
            check_flag("hdr_valid_o", hdr_valid_o, 1'b1);
            check_field("hdr_data_o", hdr_data_o, held_data);
            check_bit_cnt("hdr_bit_cnt_o", hdr_bit_cnt_o, held_bits);
            check_flag("hdr_insert_zero_o", hdr_insert_zero_o, held_zero);
            check_flag("hdr_last_o", hdr_last_o, held_last);
        end
        hold_pending = hdr_valid_o && !hdr_ready_i;
        held_data    = hdr_data_o;
        held_bits    = hdr_bit_cnt_o;
        held_zero    = hdr_insert_zero_o;
        held_last    = hdr_last_o;
        if (hdr_valid_o && hdr_ready_i) begin
            if (exp_data.size() == 0) begin
                fail_run("Header field transferred after the expected stream ran out");
            end
            e_data = exp_data.pop_front();
            e_bits = exp_bits.pop_front();
            e_zero = exp_zero.pop_front();
            e_last = exp_last.pop_front();
            check_field("hdr_data_o", hdr_data_o, e_data);
            check_bit_cnt("hdr_bit_cnt_o", hdr_bit_cnt_o, e_bits);
            check_flag("hdr_insert_zero_o", hdr_insert_zero_o, e_zero);
            check_flag("hdr_last_o", hdr_last_o, e_last);
            if (hdr_last_o) begin
                packets_done++;
            end
        end
    endtask

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------
    task automatic sample_handshakes();
        zb_fire   = zb_valid_i && zb_ready_o;
        pass_fire = pass_valid_i && pass_ready_o;
        if (zb_fire) begin
            zb_sent++;
        end
        if (pass_fire) begin
            pass_sent++;
        end
    endtask

    // Valid stays up until taken; new gaps only after a transfer
    task automatic drive_inputs();
        if (zb_sent < N_TILES * N_CB) begin
            if (!zb_valid_i || zb_fire) begin
                zb_valid_i = (rand_bits(2) != 0);
            end
            zb_data_i = tile_vals[zb_sent / N_CB][zb_sent % N_CB];
        end else begin
            zb_valid_i = 1'b0;
        end
        if (pass_sent < N_TILES * N_CB) begin
            if (!pass_valid_i || pass_fire) begin
                pass_valid_i = (rand_bits(2) != 0);
            end
            pass_data_i = pass_vals[pass_sent / N_CB][pass_sent % N_CB];
        end else begin
            pass_valid_i = 1'b0;
        end
        hdr_ready_i = (rand_bits(2) != 0);
    endtask

    initial begin
        lfsr_state   = 32'hb788_e0b3;
        rst_n        = 1'b0;
        zb_valid_i   = 1'b0;
        zb_data_i    = '0;
        pass_valid_i = 1'b0;
        pass_data_i  = '0;
        hdr_ready_i  = 1'b0;
        zb_sent      = 0;
        pass_sent    = 0;
        packets_done = 0;
        zb_fire      = 1'b0;
        pass_fire    = 1'b0;
        hold_pending = 1'b0;

        // Three tiles back to back, small counts keep bit_cnt in range
        for (t = 0; t < N_TILES; t++) begin
            for (i = 0; i < N_CB; i++) begin
                tile_vals[t][i] = t2_pkg::zb_t'(rand_bits(5));
                pass_vals[t][i] = random_pass_count();
            end
        end
        for (t = 0; t < N_TILES; t++) begin
            build_packet(t);
        end

        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        check_flag("hdr_valid_o", hdr_valid_o, 1'b0);
        check_flag("hdr_last_o", hdr_last_o, 1'b0);
        check_flag("hdr_insert_zero_o", hdr_insert_zero_o, 1'b0);
        check_flag("pass_ready_o", pass_ready_o, 1'b0);
        check_flag("zb_ready_o", zb_ready_o, 1'b1);
        drive_inputs();

        cycles = 0;
        while (packets_done < N_TILES) begin
            if (cycles == MAX_CYCLES) begin
                fail_run("Timeout: the three packet headers did not complete in time");
            end
            cycles++;
            @(negedge clk);
            sample_handshakes();
            check_header_stream();
            @(posedge clk);
            #5;
            drive_inputs();
        end

        if (exp_data.size() != 0 || zb_sent != N_TILES * N_CB ||
            pass_sent != N_TILES * N_CB) begin
            fail_run("Run ended with fields or input values left over");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/t2_pkg.sv
verilog/tag_tree_if.sv
verilog/zero_plane_fill.sv
verilog/tag_tree_level.sv
verilog/packet_header_gen.sv
verilog/t2_header_top.sv
bench/tb_clock.sv
bench/tb_t2_header.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_t2_header

run: compile
	./obj_dir/Vtb_t2_header

clean:
	rm -rf obj_dir
